// ==== hdl/mmio_pkg.sv ====
package mmio_pkg;

  // ------------------------------
  // widths and defaults
  // ------------------------------
  localparam int GCNT_W     = 64;
  localparam int LTIME_W    = 48;
  localparam int DMA_LEN_W  = 20;
  localparam int DMA_ADDR_W = 30;
  localparam int INTR_CNT_W = 32;

  // subtracted from the counter when local time is captured
  localparam int TIME_COMP = 3;

  localparam logic [INTR_CNT_W-1:0] INTR_DEFAULT = 32'd2500000;
  // byte quantities kept as 32-bit word counts
  localparam logic [DMA_LEN_W-1:0]  DMA_LEN_DEFAULT  = DMA_LEN_W'(32'h0001_0000 >> 2);
  localparam logic [DMA_ADDR_W-1:0] DMA_ADDR_DEFAULT = DMA_ADDR_W'(32'h1000_0000 >> 2);

  localparam int BAR_CSR  = 0;
  localparam int INTR_BIT = 3;

  // ------------------------------
  // register word offsets, adr[8:1]
  // ------------------------------
  localparam logic [7:0] REG_GCNT0  = 8'h02;
  localparam logic [7:0] REG_GCNT1  = 8'h03;
  localparam logic [7:0] REG_GCNT2  = 8'h04;
  localparam logic [7:0] REG_GCNT3  = 8'h05;
  localparam logic [7:0] REG_STATUS = 8'h08;
  localparam logic [7:0] REG_DLEN0  = 8'h0a;
  localparam logic [7:0] REG_DLEN1  = 8'h0b;
  localparam logic [7:0] REG_DADDR0 = 8'h10;
  localparam logic [7:0] REG_DADDR1 = 8'h11;
  localparam logic [7:0] REG_TXWR   = 8'h18;
  localparam logic [7:0] REG_TXRD   = 8'h1a;
  localparam logic [7:0] REG_CLRV0  = 8'h40;
  localparam logic [7:0] REG_CLRV1  = 8'h41;
  localparam logic [7:0] REG_SETV0  = 8'h42;
  localparam logic [7:0] REG_SETV1  = 8'h43;
  localparam logic [7:0] REG_LT0    = 8'h80;
  localparam logic [7:0] REG_LT1    = 8'h81;
  localparam logic [7:0] REG_LT2    = 8'h82;

  // ------------------------------
  // bus and config bundles
  // ------------------------------
  // one slave-bus access
  typedef struct packed {
    logic [6:0]  bar;
    logic        ce;
    logic        we;
    logic [19:1] adr;
    logic [15:0] dat;
    logic [1:0]  sel;
  } slv_req_t;

  // towards the DMA engine
  typedef struct packed {
    logic [DMA_LEN_W-1:0]  length;
    logic [DMA_ADDR_W-1:0] addr_start;
    logic                  load;
  } dma_cfg_t;

  // moderation settings, idle means no BAR0 access this cycle
  typedef struct packed {
    logic [INTR_CNT_W-1:0] clr_val;
    logic [INTR_CNT_W-1:0] set_val;
    logic                  rearm;
    logic                  idle;
  } intr_cfg_t;

endpackage

// ==== hdl/timebase.sv ====
module timebase (
  input  logic                         clk_125,
  input  logic                         sys_rst,
  input  logic                         time_req_i,
  input  logic                         bus_idle_i,
  input  logic                         ltime_wr_i,
  input  logic [1:0]                   ltime_wr_lane_i,
  input  logic [15:0]                  ltime_wr_dat_i,
  output logic [mmio_pkg::GCNT_W-1:0]  gcnt_o,
  output logic [mmio_pkg::LTIME_W-1:0] local_time_o
);
  import mmio_pkg::*;

  logic pend_q;
  logic ack_q;
  logic capture;

  // one capture per request, only while the bus is quiet
  assign capture = pend_q & ~ack_q & bus_idle_i & ~ltime_wr_i;

  // free-running global counter
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      gcnt_o <= '0;
    end else begin
      gcnt_o <= gcnt_o + 1'b1;
    end
  end

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      pend_q       <= 1'b0;
      ack_q        <= 1'b0;
      local_time_o <= '0;
    end else begin
      if (time_req_i) begin
        pend_q <= 1'b1;
      end else if (ack_q) begin
        pend_q <= 1'b0;
      end
      ack_q <= capture;
      // host write wins over a capture
      if (ltime_wr_i) begin
        local_time_o[{ltime_wr_lane_i, 4'b0000} +: 16] <= ltime_wr_dat_i;
      end else if (capture) begin
        local_time_o <= LTIME_W'(gcnt_o - GCNT_W'(TIME_COMP));
      end
    end
  end

endmodule

// ==== hdl/intr_moderator.sv ====
module intr_moderator (
  input  logic                clk_125,
  input  logic                sys_rst,
  input  logic                req_intr_i,
  input  mmio_pkg::intr_cfg_t cfg_i,
  output logic                intr_o
);
  import mmio_pkg::*;

  logic [INTR_CNT_W-1:0] holdoff_q;
  logic [INTR_CNT_W-1:0] dur_q;
  logic                  holdoff_done;

  assign holdoff_done = (holdoff_q == '0);

  // ------------------------------
  // hold-off counter
  // ------------------------------
  // loaded by a status write, counts down on idle cycles
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      holdoff_q <= '0;
    end else if (cfg_i.rearm) begin
      holdoff_q <= cfg_i.clr_val;
    end else if (cfg_i.idle && !holdoff_done) begin
      holdoff_q <= holdoff_q - 1'b1;
    end
  end

  // ------------------------------
  // interrupt flag and duration
  // ------------------------------
  // everything here freezes while the host is on the bus
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      intr_o <= 1'b0;
      dur_q  <= '0;
    end else if (cfg_i.idle) begin
      if (intr_o) begin
        if (dur_q == cfg_i.set_val) begin
          // asserted long enough
          intr_o <= 1'b0;
          dur_q  <= '0;
        end else begin
          dur_q <= dur_q + 1'b1;
        end
      end else begin
        dur_q <= '0;
        if (req_intr_i && holdoff_done) begin
          intr_o <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== hdl/csr_regs.sv ====
module csr_regs (
  input  logic                         clk_125,
  input  logic                         sys_rst,
  input  mmio_pkg::slv_req_t           slv_i,
  output logic [15:0]                  slv_dat_o,
  input  logic [mmio_pkg::GCNT_W-1:0]  gcnt_i,
  input  logic [mmio_pkg::LTIME_W-1:0] local_time_i,
  input  logic [15:0]                  tx_rd_ptr_i,
  input  logic                         intr_i,
  output mmio_pkg::dma_cfg_t           dma_cfg_o,
  output logic [15:0]                  tx_wr_ptr_o,
  output logic [7:0]                   led_o,
  output mmio_pkg::intr_cfg_t          intr_cfg_o,
  output logic                         ltime_wr_o,
  output logic [1:0]                   ltime_wr_lane_o,
  output logic [15:0]                  ltime_wr_dat_o
);
  import mmio_pkg::*;

  logic [7:0]            status_q;
  logic [7:0]            status;
  logic [DMA_LEN_W-1:0]  dma_len_q;
  logic [DMA_ADDR_W-1:0] dma_addr_q;
  logic                  load_q;
  logic [INTR_CNT_W-1:0] clr_val_q;
  logic [INTR_CNT_W-1:0] set_val_q;

  logic       acc;
  logic       in_win;
  logic       wr;
  logic [7:0] reg_ofs;
  logic       rearm;
  logic [15:0] rd_word;
  logic [15:0] new_word;

  // register word as seen on the bus, bytes exchanged
  function automatic logic [15:0] swap16(input logic [15:0] w);
    return {w[7:0], w[15:8]};
  endfunction

  // sel[1] feeds the low byte, sel[0] the high byte
  function automatic logic [15:0] lane_merge(input logic [15:0] old_w, input slv_req_t req);
    logic [15:0] w;
    w = old_w;
    if (req.sel[1]) begin
      w[7:0] = req.dat[15:8];
    end
    if (req.sel[0]) begin
      w[15:8] = req.dat[7:0];
    end
    return w;
  endfunction

  // ------------------------------
  // decode
  // ------------------------------
  assign acc     = slv_i.ce & slv_i.bar[BAR_CSR];
  assign in_win  = acc & (slv_i.adr[11:9] == 3'b000);
  assign wr      = in_win & slv_i.we;
  assign reg_ofs = slv_i.adr[8:1];

  // interrupt bit is live, the rest is stored
  always_comb begin
    status           = status_q;
    status[INTR_BIT] = intr_i;
  end

  // current register word, unswapped
  always_comb begin
    rd_word = '0;
    case (reg_ofs)
      REG_GCNT0:  rd_word = gcnt_i[15:0];
      REG_GCNT1:  rd_word = gcnt_i[31:16];
      REG_GCNT2:  rd_word = gcnt_i[47:32];
      REG_GCNT3:  rd_word = gcnt_i[GCNT_W-1:48];
      REG_STATUS: rd_word = {8'h00, status};
      REG_DLEN0:  rd_word = dma_len_q[15:0];
      REG_DLEN1:  rd_word = 16'(dma_len_q[DMA_LEN_W-1:16]);
      REG_DADDR0: rd_word = dma_addr_q[15:0];
      REG_DADDR1: rd_word = 16'(dma_addr_q[DMA_ADDR_W-1:16]);
      REG_TXWR:   rd_word = tx_wr_ptr_o;
      REG_TXRD:   rd_word = tx_rd_ptr_i;
      REG_CLRV0:  rd_word = clr_val_q[15:0];
      REG_CLRV1:  rd_word = clr_val_q[31:16];
      REG_SETV0:  rd_word = set_val_q[15:0];
      REG_SETV1:  rd_word = set_val_q[31:16];
      REG_LT0:    rd_word = local_time_i[15:0];
      REG_LT1:    rd_word = local_time_i[31:16];
      REG_LT2:    rd_word = local_time_i[47:32];
      default:    rd_word = '0;
    endcase
  end

  assign new_word = lane_merge(rd_word, slv_i);

  // ------------------------------
  // register storage
  // ------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      status_q    <= '0;
      dma_len_q   <= DMA_LEN_DEFAULT;
      dma_addr_q  <= DMA_ADDR_DEFAULT;
      load_q      <= 1'b0;
      tx_wr_ptr_o <= '0;
      clr_val_q   <= INTR_DEFAULT;
      set_val_q   <= INTR_DEFAULT;
      slv_dat_o   <= '0;
    end else begin
      load_q <= wr && (reg_ofs inside {REG_DLEN0, REG_DLEN1, REG_DADDR0, REG_DADDR1});
      // outside the window reads back zero
      if (acc && !slv_i.we) begin
        slv_dat_o <= in_win ? swap16(rd_word) : 16'h0000;
      end
      if (wr) begin
        case (reg_ofs)
          REG_STATUS: if (slv_i.sel[1]) status_q <= new_word[7:0];
          REG_DLEN0:  dma_len_q[15:0] <= new_word;
          REG_DLEN1:  dma_len_q[DMA_LEN_W-1:16] <= new_word[DMA_LEN_W-17:0];
          REG_DADDR0: dma_addr_q[15:0] <= new_word;
          REG_DADDR1: dma_addr_q[DMA_ADDR_W-1:16] <= new_word[DMA_ADDR_W-17:0];
          REG_TXWR:   tx_wr_ptr_o <= new_word;
          REG_CLRV0:  clr_val_q[15:0] <= new_word;
          REG_CLRV1:  clr_val_q[31:16] <= new_word;
          REG_SETV0:  set_val_q[15:0] <= new_word;
          REG_SETV1:  set_val_q[31:16] <= new_word;
          default: ;
        endcase
      end
    end
  end

  // status write with interrupt bit clear restarts hold-off
  assign rearm = wr & (reg_ofs == REG_STATUS) & slv_i.sel[1] & ~slv_i.dat[8 + INTR_BIT];

  assign intr_cfg_o = '{clr_val: clr_val_q, set_val: set_val_q, rearm: rearm, idle: ~acc};
  assign dma_cfg_o  = '{length: dma_len_q, addr_start: dma_addr_q, load: load_q};
  assign led_o      = ~status;

  // local time lives in timebase, send it the merged word
  assign ltime_wr_o      = wr & (reg_ofs inside {REG_LT0, REG_LT1, REG_LT2});
  assign ltime_wr_lane_o = reg_ofs[1:0];
  assign ltime_wr_dat_o  = new_word;

endmodule

// ==== hdl/ethpipe_csr_top.sv ====
module ethpipe_csr_top (
  input  logic                         clk_125,
  input  logic                         sys_rst,
  input  mmio_pkg::slv_req_t           slv_i,
  output logic [15:0]                  slv_dat_o,
  input  logic                         req_intr_i,
  input  logic                         time_req_i,
  input  logic [15:0]                  tx_rd_ptr_i,
  output logic                         sys_intr_o,
  output mmio_pkg::dma_cfg_t           dma_cfg_o,
  output logic [15:0]                  tx_wr_ptr_o,
  output logic [7:0]                   led_o,
  output logic [mmio_pkg::LTIME_W-1:0] local_time_o
);
  import mmio_pkg::*;

  logic [GCNT_W-1:0] gcnt;
  intr_cfg_t         intr_cfg;
  logic              ltime_wr;
  logic [1:0]        ltime_wr_lane;
  logic [15:0]       ltime_wr_dat;

  // counter and local-time capture
  timebase u_timebase (
    .clk_125         (clk_125),
    .sys_rst         (sys_rst),
    .time_req_i      (time_req_i),
    .bus_idle_i      (intr_cfg.idle),
    .ltime_wr_i      (ltime_wr),
    .ltime_wr_lane_i (ltime_wr_lane),
    .ltime_wr_dat_i  (ltime_wr_dat),
    .gcnt_o          (gcnt),
    .local_time_o    (local_time_o)
  );

  intr_moderator u_intr_moderator (
    .clk_125    (clk_125),
    .sys_rst    (sys_rst),
    .req_intr_i (req_intr_i),
    .cfg_i      (intr_cfg),
    .intr_o     (sys_intr_o)
  );

  // BAR0 register file
  csr_regs u_csr_regs (
    .clk_125         (clk_125),
    .sys_rst         (sys_rst),
    .slv_i           (slv_i),
    .slv_dat_o       (slv_dat_o),
    .gcnt_i          (gcnt),
    .local_time_i    (local_time_o),
    .tx_rd_ptr_i     (tx_rd_ptr_i),
    .intr_i          (sys_intr_o),
    .dma_cfg_o       (dma_cfg_o),
    .tx_wr_ptr_o     (tx_wr_ptr_o),
    .led_o           (led_o),
    .intr_cfg_o      (intr_cfg),
    .ltime_wr_o      (ltime_wr),
    .ltime_wr_lane_o (ltime_wr_lane),
    .ltime_wr_dat_o  (ltime_wr_dat)
  );

endmodule

// ==== verification/ethpipe_csr_checker.sv ====
module ethpipe_csr_checker (
  input logic                clk_125,
  input logic                sys_rst,
  input mmio_pkg::slv_req_t  slv_i,
  input logic [15:0]         slv_dat_o,
  input mmio_pkg::dma_cfg_t  dma_cfg_o,
  input logic [7:0]          led_o,
  input logic                sys_intr_o
);
  import mmio_pkg::*;

  logic status_rd;

  // host read of the status word
  assign status_rd = slv_i.ce & slv_i.bar[BAR_CSR] & ~slv_i.we
                     & (slv_i.adr[11:9] == 3'b000) & (slv_i.adr[8:1] == REG_STATUS);

  // load is a single-cycle pulse
  assert property (@(posedge clk_125) disable iff (sys_rst)
    dma_cfg_o.load |=> !dma_cfg_o.load)
    else $error("dma load high two cycles in a row");

  // status byte comes back in the upper data lane
  assert property (@(posedge clk_125) disable iff (sys_rst)
    status_rd |=> slv_dat_o[15:8] == ~$past(led_o))
    else $error("led_o differs from inverted status");

  assert property (@(posedge clk_125) sys_rst |=> !sys_intr_o)
    else $error("interrupt high during reset");

  // read data only moves after a read strobe
  assert property (@(posedge clk_125) disable iff (sys_rst)
    $changed(slv_dat_o) |-> $past(slv_i.ce && slv_i.bar[BAR_CSR] && !slv_i.we))
    else $error("read data changed without an access");

endmodule

bind ethpipe_csr_top ethpipe_csr_checker chk0 (
  .clk_125    (clk_125),
  .sys_rst    (sys_rst),
  .slv_i      (slv_i),
  .slv_dat_o  (slv_dat_o),
  .dma_cfg_o  (dma_cfg_o),
  .led_o      (led_o),
  .sys_intr_o (sys_intr_o)
);

// ==== verification/tb_ethpipe_csr.sv ====
module tb_ethpipe_csr;
  import mmio_pkg::*;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_IDLE, OP_PULSE} op_e;

  typedef struct {
    op_e         op;
    logic [7:0]  ofs;
    logic [1:0]  sel;
    logic [15:0] dat;
    logic        from_model;
    logic [15:0] exp;
  } entry_t;

  logic               clk_125;
  logic               sys_rst;
  slv_req_t           slv_i;
  logic [15:0]        slv_dat_o;
  logic               req_intr_i;
  logic               time_req_i;
  logic [15:0]        tx_rd_ptr_i;
  logic               sys_intr_o;
  dma_cfg_t           dma_cfg_o;
  logic [15:0]        tx_wr_ptr_o;
  logic [7:0]         led_o;
  logic [LTIME_W-1:0] local_time_o;

  entry_t             tbl[$];
  logic [15:0]        shadow [0:255];
  logic [15:0]        mask [0:255];
  logic [GCNT_W-1:0]  cyc;
  logic [LTIME_W-1:0] lt_model;
  int                 cycles;
  int                 cyc_limit;
  int                 n_errors;
  int                 n_checks;

  ethpipe_csr_top dut0 (.*);

  always #10 clk_125 = ~clk_125;

  // reference count is zero right after reset and one up per edge
  always @(posedge clk_125) begin
    if (sys_rst) begin
      cyc <= '0;
    end else begin
      cyc <= cyc + 1'b1;
    end
  end

  // run limit
  always @(posedge clk_125) begin
    cycles <= cycles + 1;
    if (cycles >= cyc_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cyc_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [15:0] byte_swap(input logic [15:0] w);
    return {w[7:0], w[15:8]};
  endfunction

  // bus byte 1 lands in the low register byte, bus byte 0 in the high one
  function automatic logic [15:0] merge_lanes(input logic [15:0] old_w, input logic [1:0] sel,
                                              input logic [15:0] dat);
    logic [15:0] w;
    w = old_w;
    if (sel[1]) w[7:0] = dat[15:8];
    if (sel[0]) w[15:8] = dat[7:0];
    return w;
  endfunction

  function automatic slv_req_t make_req(input logic ce, input logic we, input logic [7:0] ofs,
                                        input logic [1:0] sel, input logic [15:0] dat);
    slv_req_t r;
    r.bar = 7'b0000001;
    r.ce  = ce;
    r.we  = we;
    r.adr = {11'b0, ofs};
    r.dat = dat;
    r.sel = sel;
    return r;
  endfunction

  // expected register word before the swap
  function automatic logic [15:0] model_word(input logic [7:0] ofs);
    logic [GCNT_W-1:0] g;
    g = cyc - 1'b1;
    case (ofs)
      REG_GCNT0: return g[15:0];
      REG_GCNT1: return g[31:16];
      REG_GCNT2: return g[47:32];
      REG_GCNT3: return g[63:48];
      REG_LT0:   return lt_model[15:0];
      REG_LT1:   return lt_model[31:16];
      REG_LT2:   return lt_model[47:32];
      REG_TXRD:  return tx_rd_ptr_i;
      default:   return shadow[ofs] & mask[ofs];
    endcase
  endfunction

  task automatic add_entry(input op_e op, input logic [7:0] ofs, input logic [1:0] sel,
                           input logic [15:0] dat, input logic fm, input logic [15:0] exp);
    entry_t e;
    e = '{op: op, ofs: ofs, sel: sel, dat: dat, from_model: fm, exp: exp};
    tbl.push_back(e);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    n_errors++;
  endtask

  task automatic bus_access(input logic we, input logic [7:0] ofs, input logic [1:0] sel,
                            input logic [15:0] dat);
    @(posedge clk_125);
    slv_i <= make_req(1'b1, we, ofs, sel, dat);
    @(posedge clk_125);
    slv_i <= make_req(1'b0, 1'b0, 8'h00, 2'b00, 16'h0000);
    @(negedge clk_125);
  endtask

  task automatic write_reg(input logic [7:0] ofs, input logic [1:0] sel, input logic [15:0] dat);
    logic is_dma;
    bus_access(1'b1, ofs, sel, dat);
    is_dma = ofs inside {REG_DLEN0, REG_DLEN1, REG_DADDR0, REG_DADDR1};
    if (ofs == REG_LT0 || ofs == REG_LT1 || ofs == REG_LT2) begin
      lt_model[ofs[1:0]*16 +: 16] = merge_lanes(lt_model[ofs[1:0]*16 +: 16], sel, dat);
    end else begin
      shadow[ofs] = merge_lanes(shadow[ofs], sel, dat) & mask[ofs];
    end
    n_checks += 4;
    if (dma_cfg_o.load !== is_dma) report_mismatch("dma_cfg_o.load", is_dma, dma_cfg_o.load);
    if (dma_cfg_o.length !== {shadow[REG_DLEN1][3:0], shadow[REG_DLEN0]})
      report_mismatch("dma_cfg_o.length", {shadow[REG_DLEN1][3:0], shadow[REG_DLEN0]},
                      dma_cfg_o.length);
    if (dma_cfg_o.addr_start !== {shadow[REG_DADDR1][13:0], shadow[REG_DADDR0]})
      report_mismatch("dma_cfg_o.addr_start", {shadow[REG_DADDR1][13:0], shadow[REG_DADDR0]},
                      dma_cfg_o.addr_start);
    if (tx_wr_ptr_o !== shadow[REG_TXWR])
      report_mismatch("tx_wr_ptr_o", shadow[REG_TXWR], tx_wr_ptr_o);
  endtask

  // pulse at one edge, capture two counts earlier than the sampling edge
  task automatic pulse_time_req();
    @(posedge clk_125);
    time_req_i <= 1'b1;
    @(posedge clk_125);
    time_req_i <= 1'b0;
    @(negedge clk_125);
    lt_model = LTIME_W'(cyc - 3);
    repeat (3) @(negedge clk_125);
    n_checks++;
    if (local_time_o !== lt_model) report_mismatch("local_time_o", lt_model, local_time_o);
  endtask

  task automatic apply_entry(input entry_t e);
    logic [15:0] exp;
    case (e.op)
      OP_WR: write_reg(e.ofs, e.sel, e.dat);
      OP_RD: begin
        bus_access(1'b0, e.ofs, 2'b11, 16'h0000);
        exp = e.from_model ? byte_swap(model_word(e.ofs)) : e.exp;
        n_checks++;
        if (slv_dat_o !== exp) report_mismatch("slv_dat_o", exp, slv_dat_o);
      end
      OP_PULSE: pulse_time_req();
      default: @(negedge clk_125);
    endcase
  endtask

  // -----------------------------
  // interrupt moderation
  // -----------------------------
  task automatic run_intr_test();
    int rise_wait;
    int high_len;
    write_reg(REG_CLRV0, 2'b11, 16'h0600);
    write_reg(REG_CLRV1, 2'b11, 16'h0000);
    write_reg(REG_SETV0, 2'b11, 16'h0400);
    write_reg(REG_SETV1, 2'b11, 16'h0000);
    @(posedge clk_125);
    slv_i      <= make_req(1'b1, 1'b1, REG_STATUS, 2'b10, 16'h0000);
    req_intr_i <= 1'b1;
    @(posedge clk_125);
    slv_i <= make_req(1'b0, 1'b0, 8'h00, 2'b00, 16'h0000);
    @(negedge clk_125);
    rise_wait = 0;
    high_len  = 0;
    while (!sys_intr_o) begin
      @(negedge clk_125);
      rise_wait++;
    end
    while (sys_intr_o) begin
      n_checks++;
      if (led_o[INTR_BIT] !== 1'b0) report_mismatch("led_o[3]", 1'b0, led_o[INTR_BIT]);
      @(negedge clk_125);
      high_len++;
    end
    // hold-off counts clr_val idle cycles, duration counts 0 up to set_val
    n_checks += 2;
    if (rise_wait != 7) report_mismatch("sys_intr_o hold-off cycles", 7, rise_wait);
    if (high_len != 5) report_mismatch("sys_intr_o high cycles", 5, high_len);
    @(posedge clk_125);
    req_intr_i <= 1'b0;
  endtask

  initial begin
    logic [1:0] sels [3];
    logic [7:0] wr_regs [9];
    sels    = '{2'b01, 2'b10, 2'b11};
    wr_regs = '{REG_DLEN0, REG_DLEN1, REG_DADDR0, REG_DADDR1, REG_TXWR,
                REG_CLRV0, REG_CLRV1, REG_SETV0, REG_SETV1};
    void'($urandom(11759));
    clk_125 = 1'b0;
    sys_rst     <= 1'b1;
    slv_i       <= make_req(1'b0, 1'b0, 8'h00, 2'b00, 16'h0000);
    req_intr_i  <= 1'b0;
    time_req_i  <= 1'b0;
    tx_rd_ptr_i <= 16'ha5c3;
    cycles   = 0;
    n_errors = 0;
    n_checks = 0;
    lt_model = '0;
    foreach (shadow[i]) begin
      shadow[i] = '0;
      mask[i]   = '0;
    end
    foreach (wr_regs[i]) mask[wr_regs[i]] = 16'hffff;
    mask[REG_DLEN1]  = 16'h000f;
    mask[REG_DADDR1] = 16'h3fff;
    // interrupt bit reads live
    mask[REG_STATUS] = 16'h00f7;
    shadow[REG_DLEN0]  = DMA_LEN_DEFAULT[15:0];
    shadow[REG_DADDR1] = 16'(DMA_ADDR_DEFAULT[29:16]);
    shadow[REG_CLRV0]  = INTR_DEFAULT[15:0];
    shadow[REG_CLRV1]  = INTR_DEFAULT[31:16];
    shadow[REG_SETV0]  = INTR_DEFAULT[15:0];
    shadow[REG_SETV1]  = INTR_DEFAULT[31:16];

    foreach (wr_regs[i]) add_entry(OP_RD, wr_regs[i], 2'b11, 16'h0, 1'b1, 16'h0);
    add_entry(OP_RD, REG_STATUS, 2'b11, 16'h0, 1'b1, 16'h0);
    foreach (wr_regs[i]) begin
      foreach (sels[j]) begin
        add_entry(OP_WR, wr_regs[i], sels[j], 16'($urandom), 1'b0, 16'h0);
        add_entry(OP_RD, wr_regs[i], 2'b11, 16'h0, 1'b1, 16'h0);
      end
    end
    add_entry(OP_IDLE, 8'h00, 2'b00, 16'h0, 1'b0, 16'h0);
    for (int k = 0; k < 4; k++) add_entry(OP_RD, REG_GCNT0 + 8'(k), 2'b11, 16'h0, 1'b1, 16'h0);
    add_entry(OP_RD, REG_TXRD, 2'b11, 16'h0, 1'b1, 16'h0);
    add_entry(OP_RD, 8'h00, 2'b11, 16'h0, 1'b0, 16'h0000);
    add_entry(OP_RD, 8'h20, 2'b11, 16'h0, 1'b0, 16'h0000);
    add_entry(OP_RD, 8'hff, 2'b11, 16'h0, 1'b0, 16'h0000);
    add_entry(OP_PULSE, 8'h00, 2'b00, 16'h0, 1'b0, 16'h0);
    for (int k = 0; k < 3; k++) add_entry(OP_RD, REG_LT0 + 8'(k), 2'b11, 16'h0, 1'b1, 16'h0);
    add_entry(OP_WR, REG_LT1, 2'b11, 16'($urandom), 1'b0, 16'h0);
    add_entry(OP_RD, REG_LT1, 2'b11, 16'h0, 1'b1, 16'h0);
    cyc_limit = tbl.size() * 4 + 200;

    repeat (8) @(posedge clk_125);
    sys_rst <= 1'b0;
    @(negedge clk_125);
    n_checks += 3;
    if (sys_intr_o !== 1'b0) report_mismatch("sys_intr_o", 1'b0, sys_intr_o);
    if (led_o !== 8'hff) report_mismatch("led_o", 8'hff, led_o);
    if (local_time_o !== '0) report_mismatch("local_time_o", 0, local_time_o);

    foreach (tbl[i]) apply_entry(tbl[i]);
    run_intr_test();
    repeat (4) @(negedge clk_125);

    $display("checks: %0d  errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
hdl/mmio_pkg.sv
hdl/timebase.sv
hdl/intr_moderator.sv
hdl/csr_regs.sv
hdl/ethpipe_csr_top.sv
verification/ethpipe_csr_checker.sv
verification/tb_ethpipe_csr.sv

// ==== Bender.yml ====
package:
  name: ethpipe_csr

sources:
  - hdl/mmio_pkg.sv
  - hdl/timebase.sv
  - hdl/intr_moderator.sv
  - hdl/csr_regs.sv
  - hdl/ethpipe_csr_top.sv
  - target: test
    files:
      - verification/ethpipe_csr_checker.sv
      - verification/tb_ethpipe_csr.sv
